//--- verilog.f
+incdir+bench
rtl/xc_cfg_pkg.sv
rtl/xc_types_pkg.sv
rtl/stream_fifo.sv
rtl/line_sampler.sv
rtl/autocorrelator.sv
rtl/frame_packer.sv
rtl/uart_tx.sv
rtl/xc_firmware.sv
bench/tb_xc_firmware.sv

//--- run.sh
#!/bin/sh
# Builds the correlator testbench with Verilator and runs it.
# The exit status of the model carries pass or fail.
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_xc_firmware -f verilog.f
./obj_dir/Vtb_xc_firmware

//--- bench/tb_tasks.svh
/*
 * Testbench helpers.
 * LFSR, UART receiver, expected frames and compare tasks.
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic report_failure(input string msg);
	$display("%s", msg);
	$display("TEST FAILED");
	$fatal(1, "Simulation stopped on the first error.");
endtask

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
function automatic logic lfsr_bit();
	logic b;
	b = lfsr_state[0];
	lfsr_state = (lfsr_state >> 1) ^ (b ? 16'hB400 : 16'h0000);
	return b;
endfunction

task automatic compare_bit(input logic got, input logic exp, input string name);
	if (got !== exp) begin
		report_failure($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
	end
endtask

task automatic compare_byte(input byte_t got, input byte_t exp, input string name);
	if (got !== exp) begin
		report_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	end
endtask

task automatic compare_frame(input corr_frame_t got, input corr_frame_t exp);
	compare_byte(got.seq, exp.seq, "seq");
	for (int l = 0; l < NUM_LINES; l++) begin
		if (got.lines[l].pulses !== exp.lines[l].pulses) begin
			report_failure($sformatf("** Error at %0t: lines[%0d].pulses is %0d, expected %0d",
				$time, l, got.lines[l].pulses, exp.lines[l].pulses));
		end
		for (int k = 0; k < LAG_AUTO; k++) begin
			if (got.lines[l].lags[k] !== exp.lines[l].lags[k]) begin
				report_failure($sformatf("** Error at %0t: lines[%0d] lag %0d is %0d, expected %0d",
					$time, l, k + 1, got.lines[l].lags[k], exp.lines[l].lags[k]));
			end
		end
	end
endtask

// Constant levels over a whole window count every sample at every lag.
function automatic corr_frame_t expect_frame(input byte_t seq, input logic [NUM_LINES-1:0] levels);
	corr_frame_t f;
	f.seq = seq;
	for (int l = 0; l < NUM_LINES; l++) begin
		f.lines[l].pulses = levels[l] ? count_t'(INTEG_SAMPLES) : count_t'(0);
		for (int k = 0; k < LAG_AUTO; k++) begin
			f.lines[l].lags[k] = levels[l] ? count_t'(INTEG_SAMPLES) : count_t'(0);
		end
	end
	return f;
endfunction

// 8N1 receiver, samples tx at mid bit on falling edges.
task automatic recv_byte(output byte_t b);
	int waited;
	waited = 0;
	do begin
		@(negedge sysclk);
		waited++;
		if (waited > START_TIMEOUT) begin
			report_failure($sformatf("No UART start bit within %0d cycles.", START_TIMEOUT));
		end
	end while (tx !== 1'b0);
	repeat (BAUD_DIV / 2) @(negedge sysclk);  // Middle of the start bit.
	if (tx !== 1'b0) begin
		report_failure("UART start bit did not stay low.");
	end
	for (int i = 0; i < 8; i++) begin
		repeat (BAUD_DIV) @(negedge sysclk);
		b[i] = tx;  // LSB first.
	end
	repeat (BAUD_DIV) @(negedge sysclk);
	if (tx !== 1'b1) begin
		report_failure("UART stop bit was low.");
	end
endtask

task automatic recv_frame(output corr_frame_t f);
	byte_t hi;
	byte_t lo;
	recv_byte(hi);
	compare_byte(hi, SYNC_BYTE, "sync");  // Every frame opens with it.
	recv_byte(lo);
	f.seq = lo;
	for (int l = 0; l < NUM_LINES; l++) begin
		recv_byte(hi);
		recv_byte(lo);
		f.lines[l].pulses = {hi, lo};  // Big endian words.
		for (int k = 0; k < LAG_AUTO; k++) begin
			recv_byte(hi);
			recv_byte(lo);
			f.lines[l].lags[k] = {hi, lo};
		end
	end
endtask

`endif

//--- bench/tb_xc_firmware.sv
/*
 * Correlator testbench.
 * Drives detector lines and decodes the UART frame stream.
 */
`timescale 1ns/1ps

module tb_xc_firmware;

	import xc_cfg_pkg::*;
	import xc_types_pkg::*;

	localparam int START_TIMEOUT = 3000;  // Longer than one frame period gap.
	localparam int ROUNDS = 4;            // Constant level rounds.

	logic sysclk;
	logic rst_n;
	logic [NUM_LINES-1:0] line_in;
	logic tx;
	logic [15:0] lfsr_state;  // Level picker.
	byte_t next_seq;          // Expected seq of the next frame.

	`include "tb_tasks.svh"

	xc_firmware uut (
		.sysclk(sysclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.tx(tx)
	);

	initial begin
		sysclk = 1'b0;
		forever #5 sysclk = ~sysclk;  // 100 MHz.
	end

	// Line idles high, first frame is two thousand cycles away.
	task automatic test_idle_after_reset();
		repeat (1000) begin
			@(negedge sysclk);
			compare_bit(tx, 1'b1, "tx");
		end
	endtask

	// Lines low since reset, so frames 0 and 1 carry only zeros.
	task automatic test_quiet_frames();
		corr_frame_t got;
		repeat (2) begin
			recv_frame(got);
			compare_frame(got, expect_frame(next_seq, '0));
			next_seq = next_seq + 8'd1;
		end
	endtask

	// New levels land mid window, so the next frame is mixed and the one after is clean.
	task automatic test_constant_lines();
		logic [NUM_LINES-1:0] levels;
		corr_frame_t got;
		for (int l = 0; l < NUM_LINES; l++) begin
			levels[l] = lfsr_bit();
		end
		@(negedge sysclk);
		line_in = levels;
		recv_frame(got);
		compare_byte(got.seq, next_seq, "seq");  // Counts straddle the change.
		next_seq = next_seq + 8'd1;
		recv_frame(got);
		compare_frame(got, expect_frame(next_seq, levels));
		next_seq = next_seq + 8'd1;
	endtask

	initial begin
		rst_n = 1'b0;
		line_in = '0;
		lfsr_state = 16'd70;
		next_seq = '0;
		repeat (2) @(posedge sysclk);
		@(negedge sysclk);
		rst_n = 1'b1;
		test_idle_after_reset();
		test_quiet_frames();
		repeat (ROUNDS) test_constant_lines();
		$display("TEST OK");
		$finish;
	end

endmodule

//--- rtl/xc_firmware.sv
/*
 * Correlator top level.
 * Sampler, autocorrelator, frame packer and UART joined by stream FIFOs.
 */
`timescale 1ns/1ps

module xc_firmware (
	input  logic                             sysclk,
	input  logic                             rst_n,
	input  logic [xc_cfg_pkg::NUM_LINES-1:0] line_in,
	output logic                             tx
);

	import xc_types_pkg::*;

	sample_t smp;
	logic smp_valid;

	corr_frame_t frm_in;     // Autocorrelator to frame FIFO.
	logic frm_in_valid;
	logic frm_in_ready;
	corr_frame_t frm_out;    // Frame FIFO to packer.
	logic frm_out_valid;
	logic frm_out_ready;

	byte_t byte_in;          // Packer to byte FIFO.
	logic byte_in_valid;
	logic byte_in_ready;
	byte_t byte_out;         // Byte FIFO to UART.
	logic byte_out_valid;
	logic byte_out_ready;

	line_sampler sampler (
		.sysclk(sysclk), .rst_n(rst_n), .line_in(line_in),
		.sample(smp), .sample_valid(smp_valid)
	);

	autocorrelator correlator (
		.sysclk(sysclk), .rst_n(rst_n), .sample(smp), .sample_valid(smp_valid),
		.frame(frm_in), .frame_valid(frm_in_valid), .frame_ready(frm_in_ready)
	);

	stream_fifo #(.payload_t(corr_frame_t)) frame_fifo (
		.sysclk(sysclk), .rst_n(rst_n),
		.in_data(frm_in), .in_valid(frm_in_valid), .in_ready(frm_in_ready),
		.out_data(frm_out), .out_valid(frm_out_valid), .out_ready(frm_out_ready)
	);

	frame_packer packer (
		.sysclk(sysclk), .rst_n(rst_n),
		.frame(frm_out), .frame_valid(frm_out_valid), .frame_ready(frm_out_ready),
		.byte_data(byte_in), .byte_valid(byte_in_valid), .byte_ready(byte_in_ready)
	);

	stream_fifo #(.payload_t(byte_t)) byte_fifo (
		.sysclk(sysclk), .rst_n(rst_n),
		.in_data(byte_in), .in_valid(byte_in_valid), .in_ready(byte_in_ready),
		.out_data(byte_out), .out_valid(byte_out_valid), .out_ready(byte_out_ready)
	);

	uart_tx uart (
		.sysclk(sysclk), .rst_n(rst_n),
		.data(byte_out), .data_valid(byte_out_valid), .data_ready(byte_out_ready),
		.tx(tx)
	);

endmodule

//--- rtl/uart_tx.sv
/*
 * UART transmitter.
 * 8N1 frames, LSB first, BAUD_DIV cycles per bit.
 */
`timescale 1ns/1ps

module uart_tx (
	input  logic                sysclk,
	input  logic                rst_n,
	input  xc_types_pkg::byte_t data,
	input  logic                data_valid,
	output logic                data_ready,
	output logic                tx
);

	import xc_cfg_pkg::*;

	localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

	logic busy;
	logic [BAUD_W-1:0] baud_cnt;  // Cycles into the current bit.
	logic [3:0] bit_cnt;          // Bit being sent, start is 0, stop is 9.
	logic [9:0] shreg;            // Bit 0 drives the line.
	logic bit_end;

	assign data_ready = !busy;
	assign tx = shreg[0];
	assign bit_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			shreg <= '1;  // Line idles high.
		end else if (!busy) begin
			if (data_valid) begin
				shreg <= {1'b1, data, 1'b0};  // Stop, data, start.
				busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			shreg <= {1'b1, shreg[9:1]};  // Ones fill in behind.
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;  // Stop bit done.
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

endmodule

//--- rtl/frame_packer.sv
/*
 * Frame packer.
 * Serializes a correlation frame into a sync byte, seq and big endian counts.
 */
`timescale 1ns/1ps

module frame_packer (
	input  logic                      sysclk,
	input  logic                      rst_n,
	input  xc_types_pkg::corr_frame_t frame,
	input  logic                      frame_valid,
	output logic                      frame_ready,
	output xc_types_pkg::byte_t       byte_data,
	output logic                      byte_valid,
	input  logic                      byte_ready
);

	import xc_cfg_pkg::*;
	import xc_types_pkg::*;

	localparam int NUM_WORDS = NUM_LINES * (1 + LAG_AUTO);
	localparam int IDX_W = $clog2(FRAME_BYTES);

	logic busy;                    // A frame is being sent.
	logic [IDX_W-1:0] idx;         // Byte being offered.
	logic [IDX_W-1:0] body_idx;    // Offset past the header.
	logic [7:0] seq_q;
	count_t words [NUM_WORDS];     // Counts in send order.
	count_t cur_word;

	assign frame_ready = !busy;
	assign byte_valid = busy;

	assign body_idx = idx - IDX_W'(2);
	assign cur_word = words[body_idx[IDX_W-1:1]];  // Two bytes per word.

	always_comb begin
		if (idx == '0) begin
			byte_data = SYNC_BYTE;
		end else if (idx == IDX_W'(1)) begin
			byte_data = seq_q;
		end else if (!body_idx[0]) begin
			byte_data = byte_t'(cur_word >> 8);  // High byte first.
		end else begin
			byte_data = byte_t'(cur_word);
		end
	end

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			idx <= '0;
		end else if (frame_valid && frame_ready) begin
			busy <= 1'b1;
			idx <= '0;
		end else if (byte_valid && byte_ready) begin
			if (idx == IDX_W'(FRAME_BYTES - 1)) begin
				busy <= 1'b0;  // Last byte gone.
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Frame flattened on accept, line 0 first, pulses before lags.
	always_ff @(posedge sysclk) begin
		if (frame_valid && frame_ready) begin
			seq_q <= frame.seq;
			for (int l = 0; l < NUM_LINES; l++) begin
				words[l * (1 + LAG_AUTO)] <= frame.lines[l].pulses;
				for (int k = 0; k < LAG_AUTO; k++) begin
					words[l * (1 + LAG_AUTO) + 1 + k] <= frame.lines[l].lags[k];
				end
			end
		end
	end

endmodule

//--- rtl/autocorrelator.sv
/*
 * Autocorrelator.
 * Per line pulse and lag coincidence counters, one frame per integration.
 */
`timescale 1ns/1ps

module autocorrelator (
	input  logic                      sysclk,
	input  logic                      rst_n,
	input  xc_types_pkg::sample_t     sample,
	input  logic                      sample_valid,
	output xc_types_pkg::corr_frame_t frame,
	output logic                      frame_valid,
	input  logic                      frame_ready
);

	import xc_cfg_pkg::*;
	import xc_types_pkg::*;

	localparam int SAMP_W = $clog2(INTEG_SAMPLES);

	logic [NUM_LINES-1:0][LAG_AUTO-1:0] hist;  // Bit k is the level k+1 samples back.
	line_counts_t [NUM_LINES-1:0] acc;         // Running counts.
	line_counts_t [NUM_LINES-1:0] upd;         // Counts including the current sample.
	logic [SAMP_W-1:0] samp_cnt;               // Samples taken in this frame.
	logic [7:0] seq;                           // Number of the next frame.
	logic last;

	assign last = (samp_cnt == SAMP_W'(INTEG_SAMPLES - 1));  // Closing sample.

	// Pulse and coincidence increments for one sample.
	always_comb begin
		upd = acc;
		for (int l = 0; l < NUM_LINES; l++) begin
			if (sample.level[l]) begin
				upd[l].pulses = acc[l].pulses + 1'b1;
				for (int k = 0; k < LAG_AUTO; k++) begin
					if (hist[l][k]) begin
						upd[l].lags[k] = acc[l].lags[k] + 1'b1;  // Both ends high.
					end
				end
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			hist <= '0;
			acc <= '0;
			samp_cnt <= '0;
			seq <= '0;
			frame_valid <= 1'b0;
		end else begin
			if (sample_valid && last) begin
				frame_valid <= 1'b1;  // Out one cycle after the closing sample.
			end else if (frame_ready || sample_valid) begin
				frame_valid <= 1'b0;  // Taken, or dropped when the FIFO was full.
			end
			if (sample_valid) begin
				samp_cnt <= samp_cnt + 1'b1;  // Wraps at INTEG_SAMPLES.
				for (int l = 0; l < NUM_LINES; l++) begin
					hist[l] <= {hist[l][LAG_AUTO-2:0], sample.level[l]};  // Kept across frames.
				end
				if (last) begin
					acc <= '0;
					seq <= seq + 8'd1;  // Advances even on a drop.
				end else begin
					acc <= upd;
				end
			end
		end
	end

	// Snapshot of the finished counts.
	always_ff @(posedge sysclk) begin
		if (sample_valid && last) begin
			frame.seq <= seq;
			frame.lines <= upd;
		end
	end

endmodule

//--- rtl/line_sampler.sv
/*
 * Line sampler.
 * Synchronizes the detector lines and samples them every SAMPLE_DIV cycles.
 */
`timescale 1ns/1ps

module line_sampler (
	input  logic                             sysclk,
	input  logic                             rst_n,
	input  logic [xc_cfg_pkg::NUM_LINES-1:0] line_in,
	output xc_types_pkg::sample_t            sample,
	output logic                             sample_valid
);

	import xc_cfg_pkg::*;

	localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

	logic [NUM_LINES-1:0] sync_1;   // First stage, may go metastable.
	logic [NUM_LINES-1:0] sync_2;   // Settled levels.
	logic [DIV_W-1:0] div_cnt;      // Sample rate divider.
	logic strobe;

	assign strobe = (div_cnt == DIV_W'(SAMPLE_DIV - 1));  // Last cycle of the period.

	// Two flop synchronizer on the asynchronous lines.
	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= line_in;
			sync_2 <= sync_1;
		end
	end

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sample_valid <= 1'b0;
		end else begin
			div_cnt <= strobe ? '0 : div_cnt + 1'b1;
			sample_valid <= strobe;  // One cycle pulse per period.
		end
	end

	// Levels captured together with the strobe.
	always_ff @(posedge sysclk) begin
		if (strobe) begin
			sample.level <= sync_2;
		end
	end

endmodule

//--- rtl/stream_fifo.sv
/*
 * Stream FIFO.
 * Small circular buffer with valid/ready on both sides.
 */
`timescale 1ns/1ps

module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = xc_cfg_pkg::FIFO_DEPTH
) (
	input  logic     sysclk,
	input  logic     rst_n,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];       // Storage, no reset.
	logic [PTR_W-1:0] wr_ptr;    // Next slot to write.
	logic [PTR_W-1:0] rd_ptr;    // Oldest entry.
	logic [CNT_W-1:0] fill;      // Entries held.
	logic push;
	logic pop;

	assign in_ready = (fill != CNT_W'(DEPTH));  // Room left.
	assign out_valid = (fill != '0);            // Something to give.
	assign out_data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge sysclk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap.
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				fill <= fill + 1'b1;
			end else if (pop && !push) begin
				fill <= fill - 1'b1;
			end
		end
	end

endmodule

//--- rtl/xc_types_pkg.sv
/*
 * Correlator data types.
 * Sample, count set and frame structures carried on the internal streams.
 */
package xc_types_pkg;

	import xc_cfg_pkg::*;

	typedef logic [COUNT_BITS-1:0] count_t;  // One counter.

	typedef logic [7:0] byte_t;              // One serial byte.

	// Line levels taken at one sample strobe.
	typedef struct packed {
		logic [NUM_LINES-1:0] level;         // Bit l is line l.
	} sample_t;

	// Count set of a single line.
	typedef struct packed {
		count_t pulses;                      // Samples with the line high.
		count_t [LAG_AUTO-1:0] lags;         // Entry k holds lag k+1.
	} line_counts_t;

	// One finished integration.
	typedef struct packed {
		logic [7:0] seq;                     // Frame number, wraps at 256.
		line_counts_t [NUM_LINES-1:0] lines; // Entry l is line l.
	} corr_frame_t;

endpackage

//--- rtl/xc_cfg_pkg.sv
/*
 * Correlator configuration.
 * Line count, lag depth, sample and baud rates, counter widths.
 */
package xc_cfg_pkg;

	// Detector front end.
	localparam int NUM_LINES = 2;         // Number of detector lines.
	localparam int SAMPLE_DIV = 8;        // Sysclk cycles per sample.

	// Correlator.
	localparam int LAG_AUTO = 4;          // Highest lag counted.
	localparam int INTEG_SAMPLES = 256;   // Samples per frame.
	localparam int COUNT_BITS = 16;       // Counter width.

	// Serial link.
	localparam int BAUD_DIV = 8;          // Sysclk cycles per UART bit.
	localparam logic [7:0] SYNC_BYTE = 8'hA5;  // First byte of each frame.

	// Sync and seq, then per line one pulse word and LAG_AUTO lag words.
	localparam int FRAME_BYTES = 2 + NUM_LINES * (1 + LAG_AUTO) * 2;

	// Stream buffering.
	localparam int FIFO_DEPTH = 2;        // Entries per stream FIFO.

endpackage
